/* Bender.yml */
package:
  name: single_cpu

sources:
  - files:
      - common/cpuPkg.sv
      - rtl/fetchDecode.sv
      - rtl/regFile.sv
      - rtl/execute.sv
      - rtl/memWriteback.sv
      - rtl/singleCpu.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tbSingleCpu.sv

/* common/cpuPkg.sv */
package cpuPkg;

    // Major opcodes handled by this core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,  // Register-register ALU
        OP_IMM = 7'b0010011,  // Register-immediate ALU
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } opcode_e;

    // {inst[30], funct3}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_SUB  = 4'b1000,
        ALU_SRA  = 4'b1101
    } aluOp_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;     // Also shamt and funct7 for shift immediates
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        opcode_e    opcode;
    } sType_t;

    // Same 32 bits seen through each format
    typedef union packed {
        rType_t      r;
        iType_t      i;
        sType_t      s;
        logic [31:0] raw;
    } instWord_t;

    typedef struct packed {
        logic        regWrite;
        logic        aluSrcImm;  // Second operand from imm
        logic        memRead;
        logic        memWrite;
        aluOp_e      aluOp;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;        // Already sign-extended
    } ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] aluResult;  // Also the load/store address
        logic [31:0] storeData;
    } exStage_t;

    // Register write, doubles as the observation port
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
    } wbInfo_t;

endpackage

/* dv/cpuModel.svh */
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Architectural state as seen by the instruction stream
logic [31:0] modelRegs [32];
logic [31:0] modelMem  [DMEM_WORDS];
bit          memKnown  [DMEM_WORDS];  // Word stored at least once

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        modelRegs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
        memKnown[i] = 1'b0;
    end
endtask

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

// Low two address bits dropped, wraps at the memory size
function automatic int unsigned wordIndex(input logic [31:0] addr);
    return (addr >> 2) % DMEM_WORDS;
endfunction

// RV32I integer op by funct3, alt selects sub or sra
function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
        3'b000: r = alt ? a - b : a + b;
        3'b001: r = a << b[4:0];
        3'b010: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011: r = (a < b) ? 32'd1 : 32'd0;
        3'b100: r = a ^ b;
        3'b101: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'b110: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

// Expected writeback for one instruction against the current state
task automatic predict(input logic [31:0] ins, output logic valid,
                       output logic [4:0] rd, output logic [31:0] data);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] immI;
    a     = modelRegs[ins[19:15]];
    b     = modelRegs[ins[24:20]];
    immI  = sext12(ins[31:20]);
    rd    = ins[11:7];
    valid = 1'b0;
    data  = '0;
    case (ins[6:0])
        7'b0110011: begin  // R-type
            valid = 1'b1;
            data  = aluModel(ins[14:12], ins[30], a, b);
        end
        7'b0010011: begin  // I-type, bit 30 only counts for srai
            valid = 1'b1;
            data  = aluModel(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
        end
        7'b0000011: begin  // lw
            valid = 1'b1;
            data  = modelMem[wordIndex(a + immI)];
        end
        default: ;         // sw and unsupported opcodes
    endcase
endtask

task automatic commit(input logic [31:0] ins);
    logic        valid;
    logic [4:0]  rd;
    logic [31:0] data;
    int unsigned idx;
    predict(ins, valid, rd, data);
    if (ins[6:0] == 7'b0100011) begin
        idx = wordIndex(modelRegs[ins[19:15]] + sext12({ins[31:25], ins[11:7]}));
        modelMem[idx] = modelRegs[ins[24:20]];
        memKnown[idx] = 1'b1;
    end
    if (valid && rd != 5'd0) begin  // x0 stays zero
        modelRegs[rd] = data;
    end
endtask

`endif

/* dv/tbSingleCpu.sv */
`timescale 1ns/100ps

module tbSingleCpu import cpuPkg::*; ();

    localparam int unsigned DMEM_WORDS = 256;
    localparam int          NUM_INSTS  = 2000;
    localparam int          MAX_CYCLES = 5000;
    localparam logic [31:0] SEED       = 32'h124ec9b0;

    logic        CLK;
    logic        RST;
    logic [31:0] instAddr;
    instWord_t   inst;
    wbInfo_t     wb;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] cur;

    `include "cpuModel.svh"

    singleCpu #(.DMEM_WORDS(DMEM_WORDS)) dut_i (
        .CLK      (CLK),
        .RST      (RST),
        .instAddr (instAddr),
        .inst     (inst),
        .wb       (wb)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    endtask

    task automatic reportMismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] got);
        errors++;
        $display("Fail %s: expected %08h, got %08h", name, exp, got);
    endtask

    task automatic checkWb(input logic [31:0] ins, input int n);
        logic        expValid;
        logic [4:0]  expRd;
        logic [31:0] expData;
        predict(ins, expValid, expRd, expData);
        checks++;
        if (instAddr !== 32'(n * 4)) reportMismatch("instAddr", 32'(n * 4), instAddr);
        if (wb.valid !== expValid) reportMismatch("wb.valid", 32'(expValid), 32'(wb.valid));
        if (expValid && wb.rd !== expRd) reportMismatch("wb.rd", 32'(expRd), 32'(wb.rd));
        if (expValid && wb.data !== expData) reportMismatch("wb.data", expData, wb.data);
    endtask

    // Register-immediate op that would write rd if reset did not hold it off
    function automatic logic [31:0] resetInstruction();
        logic [31:0] word;
        word      = $urandom;
        word[6:0] = 7'b0010011;
        return word;
    endfunction

    // Random instruction, memory accesses kept inside the data memory
    function automatic logic [31:0] nextInstruction();
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] offs;
        logic [4:0]  base;
        int unsigned pick;
        int unsigned idx;
        word = $urandom;
        pick = $urandom % 100;
        idx  = $urandom % DMEM_WORDS;
        addr = idx * 4 + $urandom % 4;  // Low bits are ignored by lw/sw
        if (pick < 5) begin
            word[6:5] = 2'b11;  // No supported opcode has these set
        end else if (pick < 40) begin
            word[6:0]   = 7'b0110011;
            word[31:25] = (word[14:12] inside {3'b000, 3'b101} && word[30]) ? 7'h20 : 7'h00;
        end else if (pick < 75) begin
            word[6:0] = 7'b0010011;
            if (word[14:12] == 3'b001) word[31:25] = 7'h00;
            if (word[14:12] == 3'b101) word[31:25] = {1'b0, word[30], 5'd0};
        end else begin
            base = 5'($urandom);
            for (int k = 0; k < 32; k++) begin  // x0 always fits
                offs = addr - modelRegs[base];
                if ($signed(offs) >= -2048 && $signed(offs) <= 2047) break;
                base++;
            end
            word[19:15] = base;
            word[14:12] = 3'b010;
            if (pick >= 88 && memKnown[idx]) begin
                word[6:0]   = 7'b0000011;
                word[31:20] = offs[11:0];
            end else begin  // Unknown word gets stored first
                word[6:0]   = 7'b0100011;
                word[31:25] = offs[11:5];
                word[11:7]  = offs[4:0];
            end
        end
        return word;
    endfunction

    initial begin
        void'($urandom(SEED));
        resetModel();
        RST      = 1'b1;
        inst.raw = resetInstruction();
        for (int c = 0; c < 10; c++) begin
            @(posedge CLK);
            if (c > 0 && instAddr !== 32'd0) reportMismatch("instAddr", 32'd0, instAddr);
            if (wb.valid !== 1'b0) reportMismatch("wb.valid", 32'd0, 32'(wb.valid));
            inst.raw <= resetInstruction();
        end
        RST      <= 1'b0;
        cur      = nextInstruction();
        inst.raw <= cur;
        for (int n = 0; n < NUM_INSTS; n++) begin
            @(posedge CLK);
            checkWb(cur, n);
            commit(cur);
            cur      = nextInstruction();
            inst.raw <= cur;
        end
        finishRun();
    end

    // Watchdog
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge CLK);
        end
        errors++;
        $display("Timeout: instruction stream did not complete within %0d cycles", MAX_CYCLES);
        finishRun();
    end

endmodule

/* project.f */
+incdir+dv
common/cpuPkg.sv
rtl/fetchDecode.sv
rtl/regFile.sv
rtl/execute.sv
rtl/memWriteback.sv
rtl/singleCpu.sv
dv/tbSingleCpu.sv

/* rtl/execute.sv */
`timescale 1ns/100ps

module execute import cpuPkg::*; (
    input  ctrl_t       ctrl,
    input  logic [31:0] rd1,
    input  logic [31:0] rd2,
    output exStage_t    ex
);

    logic [31:0] opB;
    logic [4:0]  shamt;
    logic [31:0] result;

    assign opB   = ctrl.aluSrcImm ? ctrl.imm : rd2;
    assign shamt = opB[4:0];  // Low bits only, also for slli/srli/srai

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: begin
                result = rd1 + opB;
            end
            ALU_SUB: begin
                result = rd1 - opB;
            end
            ALU_SLL: begin
                result = rd1 << shamt;
            end
            ALU_SLT: begin
                result = {31'd0, $signed(rd1) < $signed(opB)};
            end
            ALU_SLTU: begin
                result = {31'd0, rd1 < opB};
            end
            ALU_XOR: begin
                result = rd1 ^ opB;
            end
            ALU_SRL: begin
                result = rd1 >> shamt;
            end
            ALU_SRA: begin
                result = $signed(rd1) >>> shamt;  // Keeps the sign bit
            end
            ALU_OR: begin
                result = rd1 | opB;
            end
            ALU_AND: begin
                result = rd1 & opB;
            end
            default: begin
                result = rd1 + opB;
            end
        endcase
    end

    always_comb begin
        ex.ctrl      = ctrl;
        ex.aluResult = result;
        ex.storeData = rd2;  // sw always stores rs2
    end

endmodule

/* rtl/fetchDecode.sv */
`timescale 1ns/100ps

module fetchDecode import cpuPkg::*; (
    input  logic        CLK,
    input  logic        RST,
    output logic [31:0] instAddr,
    input  instWord_t   inst,
    output ctrl_t       ctrl
);

    logic [31:0] pc;
    logic [2:0]  funct3;
    logic        altBit;    // inst[30] where it selects sub or sra
    logic [31:0] immI;
    logic [31:0] immS;

    // One instruction per clock, no branches
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    assign instAddr = pc;

    // funct3 sits at the same place in every format
    assign funct3 = inst.r.funct3;

    assign immI = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};

    // Bit 30 only matters for add/sub and the right shifts
    always_comb begin
        altBit = 1'b0;
        if (inst.r.opcode == OP) begin
            altBit = inst.r.funct7[5] && (funct3 == 3'b000 || funct3 == 3'b101);
        end else if (inst.r.opcode == OP_IMM) begin
            altBit = inst.r.funct7[5] && (funct3 == 3'b101);
        end
    end

    always_comb begin
        ctrl           = '0;
        ctrl.aluOp     = ALU_ADD;  // Address calculation by default
        ctrl.rs1       = inst.r.rs1;
        ctrl.rs2       = inst.r.rs2;
        ctrl.rd        = inst.r.rd;
        ctrl.imm       = immI;

        case (inst.r.opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluOp_e'({altBit, funct3});
            end
            OP_IMM: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluOp_e'({altBit, funct3});
            end
            LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.memRead   = 1'b1;
            end
            STORE: begin
                ctrl.aluSrcImm = 1'b1;
                ctrl.memWrite  = 1'b1;
                ctrl.imm       = immS;
            end
            default: ;  // Unsupported, acts as a no-op
        endcase

        // Nothing commits while held in reset
        if (RST) begin
            ctrl.regWrite  = 1'b0;
            ctrl.aluSrcImm = 1'b0;
            ctrl.memRead   = 1'b0;
            ctrl.memWrite  = 1'b0;
        end
    end

    // A store must never also update the register file downstream
    noStoreWithRegWrite : assert property (
        @(posedge CLK) !(ctrl.regWrite && ctrl.memWrite)
    );

endmodule

/* rtl/memWriteback.sv */
`timescale 1ns/100ps

module memWriteback import cpuPkg::*; #(
    parameter int unsigned DMEM_WORDS = 256
) (
    input  logic     CLK,
    input  logic     RST,
    input  exStage_t ex,
    output wbInfo_t  wb
);

    localparam int unsigned IDX_BITS = $clog2(DMEM_WORDS);

    logic [31:0]         dmem [DMEM_WORDS];
    logic [IDX_BITS-1:0] wordIdx;
    logic [31:0]         loadData;

    // Word addressed, upper bits wrap around
    assign wordIdx  = ex.aluResult[IDX_BITS+1:2];
    assign loadData = dmem[wordIdx];

    // Store lands at the edge, a load in the same cycle sees the old word
    always_ff @(posedge CLK) begin
        if (ex.ctrl.memWrite) begin
            dmem[wordIdx] <= ex.storeData;
        end
    end

    always_comb begin
        wb.valid = ex.ctrl.regWrite;
        wb.rd    = ex.ctrl.rd;
        wb.data  = ex.ctrl.memRead ? loadData : ex.aluResult;
    end

    noLoadStoreOverlap : assert property (
        @(posedge CLK) disable iff (RST)
        !(ex.ctrl.memRead && ex.ctrl.memWrite)
    );

endmodule

/* rtl/regFile.sv */
`timescale 1ns/100ps

module regFile import cpuPkg::*; (
    input  logic        CLK,
    input  logic        RST,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  wbInfo_t     wb
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;  // x0 writes dropped here
        end
    end

    // Asynchronous reads, x0 holds its reset value
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

    // x0 stays zero even after writeback reported a value for it
    x0ReadsZero : assert property (
        @(posedge CLK) disable iff (RST)
        (rs1 == 5'd0) |-> (rd1 == 32'd0)
    );

endmodule

/* rtl/singleCpu.sv */
`timescale 1ns/100ps

module singleCpu import cpuPkg::*; #(
    parameter int unsigned DMEM_WORDS = 256  // Power of two
) (
    input  logic        CLK,
    input  logic        RST,
    output logic [31:0] instAddr,
    input  instWord_t   inst,
    output wbInfo_t     wb
);

    ctrl_t       ctrl;
    logic [31:0] rd1;
    logic [31:0] rd2;
    exStage_t    ex;

    // Fetch and decode
    fetchDecode uFetchDecode (
        .CLK      (CLK),
        .RST      (RST),
        .instAddr (instAddr),
        .inst     (inst),
        .ctrl     (ctrl)
    );

    // Register read, written back from wb
    regFile uRegFile (
        .CLK (CLK),
        .RST (RST),
        .rs1 (ctrl.rs1),
        .rs2 (ctrl.rs2),
        .rd1 (rd1),
        .rd2 (rd2),
        .wb  (wb)
    );

    execute uExecute (
        .ctrl (ctrl),
        .rd1  (rd1),
        .rd2  (rd2),
        .ex   (ex)
    );

    memWriteback #(
        .DMEM_WORDS (DMEM_WORDS)
    ) uMemWriteback (
        .CLK (CLK),
        .RST (RST),
        .ex  (ex),
        .wb  (wb)
    );

endmodule
